// File: logic/vid_params.svh
`ifndef VID_PARAMS_SVH
`define VID_PARAMS_SVH

////////////////////////////////////////////////////////////
// raster geometry, in pixel clocks and lines
////////////////////////////////////////////////////////////

// horizontal, one pixel per clk
`define H_ACTIVE      16
`define H_SYNC_START  18
`define H_SYNC_END    21
`define H_TOTAL       24

// vertical, in lines
`define V_ACTIVE      8
`define V_SYNC_START  9
`define V_SYNC_END    11
`define V_TOTAL       12

////////////////////////////////////////////////////////////
// data path widths
////////////////////////////////////////////////////////////

`define POS_W         8
`define DOT_W         4
`define COMP_W        4
`define PAL_DEPTH     16

`endif

// File: logic/vid_pkg.sv
`include "vid_params.svh"

package vid_pkg;

	////////////////////////////////////////////////////////////
	// host side
	////////////////////////////////////////////////////////////

	// write target select, 2 bits on the host bus
	typedef enum logic [1:0] {
		OP_SCROLL_X  = 2'd0,
		OP_SCROLL_Y  = 2'd1,
		OP_BACKCOLOR = 2'd2,
		OP_PALETTE   = 2'd3
	} host_op_e;

	// one host write, held while req is high
	typedef struct packed {
		host_op_e                  op;
		logic [`DOT_W-1:0]         addr;
		logic [3*`COMP_W-1:0]      data;
	} host_wr_t;

	// four-phase slave states
	typedef enum logic {
		HS_IDLE = 1'b0,
		HS_ACK  = 1'b1
	} hs_state_e;

	// palette port, en is a single-cycle strobe
	typedef struct packed {
		logic                      en;
		logic [`DOT_W-1:0]         idx;
		logic [3*`COMP_W-1:0]      rgb;
	} pal_wr_t;

	////////////////////////////////////////////////////////////
	// raster side
	////////////////////////////////////////////////////////////

	// beam position plus its decoded flags, all active low
	typedef struct packed {
		logic [`POS_W-1:0]         hpos;
		logic [`POS_W-1:0]         vpos;
		logic                      hsync_n;
		logic                      vsync_n;
		logic                      hblank_n;
		logic                      vblank_n;
	} beam_t;

endpackage

// File: logic/video_timing.sv
`timescale 1ns/1ps

`include "vid_params.svh"

module video_timing (
	input  logic           clk,
	input  logic           rst_n,
	output vid_pkg::beam_t beam
);

	////////////////////////////////////////////////////////////
	// next position
	////////////////////////////////////////////////////////////

	logic              h_wrap;
	logic              v_wrap;
	logic [`POS_W-1:0] h_nxt;
	logic [`POS_W-1:0] v_nxt;

	always_comb begin
		// end of line / end of frame
		h_wrap = (beam.hpos == `POS_W'(`H_TOTAL - 1));
		v_wrap = (beam.vpos == `POS_W'(`V_TOTAL - 1));
		h_nxt  = h_wrap ? '0 : beam.hpos + 1'b1;
		// line counter steps only on the horizontal wrap
		if (h_wrap) begin
			v_nxt = v_wrap ? '0 : beam.vpos + 1'b1;
		end else begin
			v_nxt = beam.vpos;
		end
	end

	////////////////////////////////////////////////////////////
	// flag decode for the next position
	////////////////////////////////////////////////////////////

	logic hsync_nxt_n;
	logic vsync_nxt_n;
	logic hblank_nxt_n;
	logic vblank_nxt_n;

	always_comb begin
		// sync window is [start, end)
		hsync_nxt_n  = !((h_nxt >= `H_SYNC_START) && (h_nxt < `H_SYNC_END));
		vsync_nxt_n  = !((v_nxt >= `V_SYNC_START) && (v_nxt < `V_SYNC_END));
		// blank outside the active area
		hblank_nxt_n = (h_nxt < `H_ACTIVE);
		vblank_nxt_n = (v_nxt < `V_ACTIVE);
	end

	////////////////////////////////////////////////////////////
	// beam register
	////////////////////////////////////////////////////////////

	// counters live in the beam itself so flags always match position
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beam.hpos     <= '0;
			beam.vpos     <= '0;
			beam.hsync_n  <= 1'b1;
			beam.vsync_n  <= 1'b1;
			beam.hblank_n <= 1'b1;
			beam.vblank_n <= 1'b1;
		end else begin
			beam.hpos     <= h_nxt;
			beam.vpos     <= v_nxt;
			beam.hsync_n  <= hsync_nxt_n;
			beam.vsync_n  <= vsync_nxt_n;
			beam.hblank_n <= hblank_nxt_n;
			beam.vblank_n <= vblank_nxt_n;
		end
	end

	// counters never leave the raster
	a_hpos_range: assert property (@(posedge clk) disable iff (!rst_n)
		beam.hpos < `H_TOTAL);
	a_vpos_range: assert property (@(posedge clk) disable iff (!rst_n)
		beam.vpos < `V_TOTAL);

endmodule

// File: logic/host_regs.sv
`timescale 1ns/1ps

`include "vid_params.svh"

module host_regs (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   host_req,
	input  vid_pkg::host_wr_t      host_cmd,
	output logic                   host_ack,
	output logic [`POS_W-1:0]      scroll_x,
	output logic [`POS_W-1:0]      scroll_y,
	output logic [`DOT_W-1:0]      back_idx,
	output vid_pkg::pal_wr_t       pal_wr
);

	vid_pkg::hs_state_e       state;
	logic                     wr_take;
	logic                     pal_en;
	logic [`DOT_W-1:0]        pal_idx;
	logic [3*`COMP_W-1:0]     pal_rgb;

	// new request seen while idle
	assign wr_take = (state == vid_pkg::HS_IDLE) && host_req;

	////////////////////////////////////////////////////////////
	// four-phase slave and register decode
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= vid_pkg::HS_IDLE;
			scroll_x <= '0;
			scroll_y <= '0;
			back_idx <= '0;
			pal_en   <= 1'b0;
		end else begin
			// palette strobe lasts one clk
			pal_en <= 1'b0;
			case (state)
				vid_pkg::HS_IDLE: begin
					if (host_req) begin
						state <= vid_pkg::HS_ACK;
						// write lands on the same edge that raises ack
						case (host_cmd.op)
							vid_pkg::OP_SCROLL_X:  scroll_x <= host_cmd.data[`POS_W-1:0];
							vid_pkg::OP_SCROLL_Y:  scroll_y <= host_cmd.data[`POS_W-1:0];
							vid_pkg::OP_BACKCOLOR: back_idx <= host_cmd.data[`DOT_W-1:0];
							vid_pkg::OP_PALETTE:   pal_en   <= 1'b1;
							default:               pal_en   <= 1'b0;
						endcase
					end
				end
				vid_pkg::HS_ACK: begin
					// hold ack until master lets go of req
					if (!host_req) begin
						state <= vid_pkg::HS_IDLE;
					end
				end
				default: state <= vid_pkg::HS_IDLE;
			endcase
		end
	end

	// palette payload, captured with the request
	always_ff @(posedge clk) begin
		if (wr_take) begin
			pal_idx <= host_cmd.addr;
			pal_rgb <= host_cmd.data;
		end
	end

	assign host_ack = (state == vid_pkg::HS_ACK);
	assign pal_wr   = '{en: pal_en, idx: pal_idx, rgb: pal_rgb};

	////////////////////////////////////////////////////////////
	// protocol checks
	////////////////////////////////////////////////////////////

	// ack only answers a request
	a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(host_ack) |-> $past(host_req));
	// master keeps the command steady during the transfer
	a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(host_req && $past(host_req)) |-> $stable(host_cmd));

endmodule

// File: logic/pattern_layer.sv
`timescale 1ns/1ps

`include "vid_params.svh"

module pattern_layer (
	input  logic                clk,
	input  logic                rst_n,
	input  vid_pkg::beam_t      beam,
	input  logic [`POS_W-1:0]   scroll_x,
	input  logic [`POS_W-1:0]   scroll_y,
	input  logic [`DOT_W-1:0]   back_idx,
	output logic [`DOT_W-1:0]   dot,
	output vid_pkg::beam_t      beam_d
);

	////////////////////////////////////////////////////////////
	// scrolled pattern
	////////////////////////////////////////////////////////////

	logic [`POS_W-1:0] sx;
	logic [`POS_W-1:0] sy;
	logic [`DOT_W-1:0] raw_idx;
	logic [`DOT_W-1:0] dot_nxt;

	always_comb begin
		// plain 8-bit add, wraps at 256
		sx      = beam.hpos + scroll_x;
		sy      = beam.vpos + scroll_y;
		// 4x4 checker of indices, row bits above column bits
		raw_idx = {sy[1:0], sx[1:0]};
		// index 0 is see-through, back colour shows instead
		dot_nxt = (raw_idx == '0) ? back_idx : raw_idx;
	end

	////////////////////////////////////////////////////////////
	// output stage
	////////////////////////////////////////////////////////////

	// beam travels with its dot so the next stage stays aligned
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dot             <= '0;
			beam_d.hpos     <= '0;
			beam_d.vpos     <= '0;
			beam_d.hsync_n  <= 1'b1;
			beam_d.vsync_n  <= 1'b1;
			beam_d.hblank_n <= 1'b1;
			beam_d.vblank_n <= 1'b1;
		end else begin
			dot    <= dot_nxt;
			beam_d <= beam;
		end
	end

endmodule

// File: logic/color_lut.sv
`timescale 1ns/1ps

`include "vid_params.svh"

module color_lut (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [`DOT_W-1:0]    dot,
	input  vid_pkg::beam_t       beam_d,
	input  vid_pkg::pal_wr_t     pal_wr,
	output logic [`COMP_W-1:0]   red,
	output logic [`COMP_W-1:0]   green,
	output logic [`COMP_W-1:0]   blue,
	output logic                 hsync_n,
	output logic                 vsync_n,
	output logic                 hblank_n,
	output logic                 vblank_n
);

	////////////////////////////////////////////////////////////
	// palette, 16 x 12-bit rgb
	////////////////////////////////////////////////////////////

	logic [3*`COMP_W-1:0] pal_mem [`PAL_DEPTH];

	// cleared at reset, host writes one entry per strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `PAL_DEPTH; i++) begin
				pal_mem[i] <= '0;
			end
		end else if (pal_wr.en) begin
			pal_mem[pal_wr.idx] <= pal_wr.rgb;
		end
	end

	////////////////////////////////////////////////////////////
	// lookup and blanking
	////////////////////////////////////////////////////////////

	logic                 blank;
	logic [3*`COMP_W-1:0] rgb_nxt;

	always_comb begin
		blank   = !beam_d.hblank_n || !beam_d.vblank_n;
		// black outside the active area
		rgb_nxt = blank ? '0 : pal_mem[dot];
	end

	// colour and flags leave on the same edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			{red, green, blue} <= '0;
			hsync_n            <= 1'b1;
			vsync_n            <= 1'b1;
			hblank_n           <= 1'b1;
			vblank_n           <= 1'b1;
		end else begin
			red      <= rgb_nxt[3*`COMP_W-1:2*`COMP_W];
			green    <= rgb_nxt[2*`COMP_W-1:`COMP_W];
			blue     <= rgb_nxt[`COMP_W-1:0];
			hsync_n  <= beam_d.hsync_n;
			vsync_n  <= beam_d.vsync_n;
			hblank_n <= beam_d.hblank_n;
			vblank_n <= beam_d.vblank_n;
		end
	end

	// no colour leaks into blanking
	a_blank_black: assert property (@(posedge clk) disable iff (!rst_n)
		(!hblank_n || !vblank_n) |-> ({red, green, blue} == '0));

endmodule

// File: logic/video_board.sv
`timescale 1ns/1ps

`include "vid_params.svh"

module video_board (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 host_req,
	input  vid_pkg::host_wr_t    host_cmd,
	output logic                 host_ack,
	output logic [`COMP_W-1:0]   red,
	output logic [`COMP_W-1:0]   green,
	output logic [`COMP_W-1:0]   blue,
	output logic                 hsync_n,
	output logic                 vsync_n,
	output logic                 hblank_n,
	output logic                 vblank_n
);

	////////////////////////////////////////////////////////////
	// internal nets
	////////////////////////////////////////////////////////////

	vid_pkg::beam_t      beam;
	vid_pkg::beam_t      beam_d;
	vid_pkg::pal_wr_t    pal_wr;
	logic [`POS_W-1:0]   scroll_x;
	logic [`POS_W-1:0]   scroll_y;
	logic [`DOT_W-1:0]   back_idx;
	logic [`DOT_W-1:0]   dot;

	// raster counters
	video_timing u_timing (.clk(clk), .rst_n(rst_n), .beam(beam));

	// host writes, scroll and palette
	host_regs u_regs (.clk(clk), .rst_n(rst_n), .host_req(host_req), .host_cmd(host_cmd),
		.host_ack(host_ack), .scroll_x(scroll_x), .scroll_y(scroll_y),
		.back_idx(back_idx), .pal_wr(pal_wr));

	// scrolled pattern, +1 clk
	pattern_layer u_layer (.clk(clk), .rst_n(rst_n), .beam(beam), .scroll_x(scroll_x),
		.scroll_y(scroll_y), .back_idx(back_idx), .dot(dot), .beam_d(beam_d));

	// palette lookup, +1 clk
	color_lut u_lut (.clk(clk), .rst_n(rst_n), .dot(dot), .beam_d(beam_d), .pal_wr(pal_wr),
		.red(red), .green(green), .blue(blue), .hsync_n(hsync_n), .vsync_n(vsync_n),
		.hblank_n(hblank_n), .vblank_n(vblank_n));

endmodule

// File: bench/video_board_tb.sv
`timescale 1ns/1ps

`include "vid_params.svh"

module video_board_tb;

	logic                   clk;
	logic                   rst_n;
	logic                   host_req;
	vid_pkg::host_wr_t      host_cmd;
	logic                   host_ack;
	logic [`COMP_W-1:0]     red;
	logic [`COMP_W-1:0]     green;
	logic [`COMP_W-1:0]     blue;
	logic                   hsync_n;
	logic                   vsync_n;
	logic                   hblank_n;
	logic                   vblank_n;

	// reference copies of the host registers
	logic [`POS_W-1:0]      m_scroll_x;
	logic [`POS_W-1:0]      m_scroll_y;
	logic [`DOT_W-1:0]      m_back;
	logic [3*`COMP_W-1:0]   m_pal [`PAL_DEPTH];

	// parsed vector records
	byte                    rec_kind [$];
	logic [31:0]            rec_a [$];
	logic [31:0]            rec_b [$];
	logic [31:0]            rec_c [$];

	int                     cycles;
	int                     limit;

	video_board u_dut (.clk(clk), .rst_n(rst_n), .host_req(host_req), .host_cmd(host_cmd),
		.host_ack(host_ack), .red(red), .green(green), .blue(blue), .hsync_n(hsync_n),
		.vsync_n(vsync_n), .hblank_n(hblank_n), .vblank_n(vblank_n));

	// 20 ns pixel clock
	always #10 clk = ~clk;

	////////////////////////////////////////////////////////////
	// reporting
	////////////////////////////////////////////////////////////

	task automatic stop_run();
		$display("sim failed");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s got %h exp %h", name, got, exp);
			stop_run();
		end
	endtask

	// idle outputs, used in and just after reset
	task automatic check_idle();
		check_val("host_ack", 32'(host_ack), 32'd0);
		check_val("hsync_n", 32'(hsync_n), 32'd1);
		check_val("vsync_n", 32'(vsync_n), 32'd1);
		check_val("hblank_n", 32'(hblank_n), 32'd1);
		check_val("vblank_n", 32'(vblank_n), 32'd1);
		check_val("rgb", 32'({red, green, blue}), 32'd0);
	endtask

	// cycle budget, ends a hung run
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout: run did not finish");
			stop_run();
		end
	end

	// colour must be black whenever any blank output is low
	always @(negedge clk) begin
		if (rst_n && (!hblank_n || !vblank_n)) begin
			check_val("rgb_in_blank", 32'({red, green, blue}), 32'd0);
		end
	end

	////////////////////////////////////////////////////////////
	// vector file
	////////////////////////////////////////////////////////////

	task automatic load_vectors();
		int          fd;
		int          nf;
		int          done;
		string       line;
		byte         ch;
		logic [31:0] va;
		logic [31:0] vb;
		logic [31:0] vc;
		fd   = $fopen("bench/video_vectors.txt", "r");
		done = 0;
		if (fd == 0) begin
			$display("cannot open bench/video_vectors.txt");
			stop_run();
		end
		while (done == 0) begin
			if ($fgets(line, fd) == 0) begin
				$display("vectors file ends without an E record");
				stop_run();
			end
			ch = (line.len() > 0) ? line[0] : 8'h0a;
			// comments and blank lines
			if (ch == "#" || ch == 8'h0a || ch == 8'h0d) begin
				nf = 0;
			end else if (ch == "W") begin
				nf = $sscanf(line, "W %h %h %h", va, vb, vc);
				if (nf != 3) begin
					$display("bad write record in vectors file: %s", line);
					stop_run();
				end
				rec_kind.push_back(ch);
				rec_a.push_back(va);
				rec_b.push_back(vb);
				rec_c.push_back(vc);
			end else if (ch == "F") begin
				nf = $sscanf(line, "F %d", va);
				if (nf != 1) begin
					$display("bad frame record in vectors file: %s", line);
					stop_run();
				end
				rec_kind.push_back(ch);
				rec_a.push_back(va);
				rec_b.push_back(32'd0);
				rec_c.push_back(32'd0);
			end else if (ch == "E") begin
				done = 1;
			end else begin
				$display("unknown record in vectors file: %s", line);
				stop_run();
			end
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	task automatic apply_model(input logic [1:0] op, input logic [3:0] addr,
		input logic [11:0] data);
		case (op)
			2'd0: m_scroll_x = data[7:0];
			2'd1: m_scroll_y = data[7:0];
			2'd2: m_back = data[3:0];
			default: m_pal[addr] = data;
		endcase
	endtask

	// pixel (h, v) counted from the top left of the visible frame
	function automatic logic [11:0] exp_rgb(input int h, input int v);
		logic [7:0] sx;
		logic [7:0] sy;
		logic [3:0] idx;
		sx  = 8'(h) + m_scroll_x;
		sy  = 8'(v) + m_scroll_y;
		idx = {sy[1:0], sx[1:0]};
		// index 0 falls through to the back colour
		if (idx == 4'd0) begin
			idx = m_back;
		end
		return m_pal[idx];
	endfunction

	////////////////////////////////////////////////////////////
	// host driver, four-phase
	////////////////////////////////////////////////////////////

	task automatic host_write(input logic [1:0] op, input logic [3:0] addr,
		input logic [11:0] data);
		int gap;
		int wait_cnt;
		gap = int'($urandom % 6);
		repeat (gap) @(negedge clk);
		// only touch registers during vertical blank
		while (vblank_n !== 1'b0) @(negedge clk);
		check_val("host_ack", 32'(host_ack), 32'd0);
		host_cmd.op   = vid_pkg::host_op_e'(op);
		host_cmd.addr = addr;
		host_cmd.data = data;
		host_req      = 1'b1;
		@(negedge clk);
		wait_cnt = 1;
		while (host_ack !== 1'b1) begin
			@(negedge clk);
			wait_cnt++;
		end
		// ack one clk after req
		check_val("ack_rise_cycles", 32'(wait_cnt), 32'd1);
		apply_model(op, addr, data);
		gap = int'($urandom % 6);
		repeat (gap) begin
			@(negedge clk);
			check_val("host_ack", 32'(host_ack), 32'd1);
		end
		host_req = 1'b0;
		@(negedge clk);
		wait_cnt = 1;
		while (host_ack !== 1'b0) begin
			@(negedge clk);
			wait_cnt++;
		end
		check_val("ack_fall_cycles", 32'(wait_cnt), 32'd1);
	endtask

	////////////////////////////////////////////////////////////
	// frame checker
	////////////////////////////////////////////////////////////

	task automatic check_frames(input int n);
		int h;
		int v;
		int act_cnt;
		int hs_cnt;
		int act_lines;
		int vs_cycles;
		// sync to the first active cycle after vblank
		while (vblank_n !== 1'b0) @(negedge clk);
		while (vblank_n !== 1'b1) @(negedge clk);
		for (int f = 0; f < n; f++) begin
			v         = 0;
			act_lines = 0;
			vs_cycles = 0;
			check_val("vblank_n_frame_start", 32'(vblank_n), 32'd1);
			for (int line = 0; line < `V_TOTAL; line++) begin
				h       = 0;
				act_cnt = 0;
				hs_cnt  = 0;
				// every line opens with active pixels
				check_val("hblank_n_line_start", 32'(hblank_n), 32'd1);
				for (int col = 0; col < `H_TOTAL; col++) begin
					if (hblank_n) act_cnt++;
					if (!hsync_n) hs_cnt++;
					if (!vsync_n) vs_cycles++;
					if (hblank_n && vblank_n) begin
						check_val("rgb", 32'({red, green, blue}), 32'(exp_rgb(h, v)));
						h++;
					end
					@(negedge clk);
				end
				check_val("hblank_n_high_cycles", 32'(act_cnt), `H_ACTIVE);
				check_val("hsync_n_low_cycles", 32'(hs_cnt), `H_SYNC_END - `H_SYNC_START);
				if (h != 0) begin
					act_lines++;
					v++;
				end
			end
			check_val("vblank_n_high_lines", 32'(act_lines), `V_ACTIVE);
			check_val("vsync_n_low_cycles", 32'(vs_cycles),
				(`V_SYNC_END - `V_SYNC_START) * `H_TOTAL);
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int unsigned seed;
		int          n_frames;
		int          n_writes;
		int          n_checks;
		clk        = 1'b0;
		rst_n      = 1'b0;
		host_req   = 1'b0;
		host_cmd   = '0;
		cycles     = 0;
		limit      = 0;
		m_scroll_x = '0;
		m_scroll_y = '0;
		m_back     = '0;
		n_frames   = 0;
		n_writes   = 0;
		n_checks   = 0;
		seed       = 32'h5f88_84ac;
		void'($urandom(seed));
		for (int i = 0; i < `PAL_DEPTH; i++) begin
			m_pal[i] = '0;
		end
		load_vectors();
		for (int i = 0; i < rec_kind.size(); i++) begin
			if (rec_kind[i] == "W") begin
				n_writes++;
			end else begin
				n_checks++;
				n_frames += int'(rec_a[i]);
			end
		end
		// each record may also wait up to a frame for vblank
		limit = (n_frames + n_checks + n_writes) * (`H_TOTAL * `V_TOTAL)
			+ n_writes * 40 + 200;
		repeat (16) begin
			@(negedge clk);
			check_idle();
		end
		rst_n = 1'b1;
		@(negedge clk);
		check_idle();
		for (int i = 0; i < rec_kind.size(); i++) begin
			if (rec_kind[i] == "W") begin
				host_write(rec_a[i][1:0], rec_b[i][3:0], rec_c[i][11:0]);
			end else begin
				check_frames(int'(rec_a[i]));
			end
		end
		$display("sim passed");
		$finish;
	end

endmodule

// File: bench/video_vectors.txt
# W op addr data : host write, hex (op 0 scroll_x, 1 scroll_y, 2 back colour, 3 palette)
# F n : check n frames, decimal ; E : end of records
F 2
W 3 0 123
W 3 1 F00
W 3 2 0F0
W 3 3 00F
W 3 4 FF0
W 3 5 0FF
W 3 6 F0F
W 3 7 888
W 3 8 444
W 3 9 C30
W 3 A 3C0
W 3 B 03C
W 3 C 9AB
W 3 D 5E7
W 3 E D21
W 3 F FFF
W 2 0 005
F 1
W 0 0 003
W 1 0 002
F 1
W 0 0 0FE
W 1 0 0FB
F 1
W 2 0 000
W 0 0 081
W 1 0 0C6
F 1
E

// File: build.f
+incdir+logic
logic/vid_pkg.sv
logic/video_timing.sv
logic/host_regs.sv
logic/pattern_layer.sv
logic/color_lut.sv
logic/video_board.sv
bench/video_board_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the video_board testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f build.f --top-module video_board_tb \
	> build.log 2>&1 || { echo "compile failed, see build.log"; exit 1; }

./obj_dir/Vvideo_board_tb > sim.log 2>&1
cat sim.log

grep -q "sim passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
